//--- rtl/avg_pkg.sv
package avg_pkg;

   // ------------------------------
   // sizes
   // ------------------------------

   localparam int N_LANES  = 4;   // one averaging lane per channel.
   localparam int SAMPLE_W = 8;
   localparam int CNT_W    = 8;   // a burst holds at most 255 samples.
   localparam int SUM_W    = 16;  // 255 samples of 255 still fit.
   localparam int CHAN_W   = 2;

   // ------------------------------
   // types
   // ------------------------------

   typedef logic [SAMPLE_W-1:0] sample_t;  // a sample, and also the mean.
   typedef logic [CNT_W-1:0]    count_t;   // the sample count, and also the remainder.
   typedef logic [SUM_W-1:0]    sum_t;     // running sum and dividend.
   typedef logic [CHAN_W-1:0]   chan_t;

   // the lane accumulates a burst, divides, then holds its result until the next sample.
   typedef enum logic [1:0] {
      IDLE,
      ACCUM,
      DIVIDE,
      DONE
   } lane_state_t;

endpackage

//--- rtl/avg_result_if.sv
`timescale 1ns/10ps

// one lane's result as seen by the collector.
interface avg_result_if import avg_pkg::*; ();

   logic    done;   // single-cycle strobe when a new result is ready.
   sample_t mean;
   count_t  rem;
   count_t  count;

   // the values stay stable until the lane finishes its next burst.
   modport lane (
      output done,
      output mean,
      output rem,
      output count
   );

   modport collector (
      input done,
      input mean,
      input rem,
      input count
   );

endinterface

//--- rtl/sample_router.sv
`timescale 1ns/10ps

module sample_router import avg_pkg::*; (
   input  logic               clk,
   input  logic               rstn,
   input  logic               in_valid,
   input  chan_t              in_chan,
   input  sample_t            in_sample,
   input  logic               in_last,
   output logic [N_LANES-1:0] lane_valid,
   output sample_t            lane_sample,
   output logic               lane_last
);

   logic [N_LANES-1:0] sel;

   // one-hot decode of the channel number.
   always_comb begin
      sel = '0;
      sel[in_chan] = in_valid;
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         lane_valid <= '0;
      end else begin
         lane_valid <= sel;
      end
   end

   // sample and last flag are shared by all lanes and qualified by lane_valid.
   always_ff @(posedge clk) begin
      lane_sample <= in_sample;
      lane_last   <= in_last;
   end

endmodule

//--- rtl/serial_divider.sv
`timescale 1ns/10ps

module serial_divider import avg_pkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  logic    start,
   input  sum_t    dividend,
   input  count_t  divisor,
   output logic    finish,
   output sample_t quotient,
   output count_t  remainder
);

   typedef logic [$clog2(SUM_W+1)-1:0] bitcnt_t;

   bitcnt_t        bits_left;
   sum_t           shreg;      // dividend bits leave at the top, quotient bits enter below.
   count_t         rem_q;
   count_t         div_q;
   logic [CNT_W:0] trial;
   logic [CNT_W:0] diff;
   logic           fits;

   // the partial remainder is always below the divisor, so one extra bit is enough.
   assign trial = {rem_q, shreg[SUM_W-1]};
   assign diff  = trial - {1'b0, div_q};
   assign fits  = (trial >= {1'b0, div_q});

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         bits_left <= '0;
         finish    <= 1'b0;
      end else begin
         finish <= !start && (bits_left == bitcnt_t'(1));
         if (start) begin
            bits_left <= bitcnt_t'(SUM_W);
         end else if (bits_left != '0) begin
            bits_left <= bits_left - bitcnt_t'(1);
         end
      end
   end

   // ------------------------------
   // datapath
   // ------------------------------

   always_ff @(posedge clk) begin
      if (start) begin
         shreg <= dividend;
         rem_q <= '0;
         div_q <= divisor;
      end else if (bits_left != '0) begin
         shreg <= {shreg[SUM_W-2:0], fits};
         rem_q <= fits ? diff[CNT_W-1:0] : trial[CNT_W-1:0];
      end
   end

   // the mean never exceeds the largest sample, so the high quotient bits are zero.
   assign quotient  = shreg[SAMPLE_W-1:0];
   assign remainder = rem_q;

endmodule

//--- rtl/burst_averager.sv
`timescale 1ns/10ps

module burst_averager import avg_pkg::*; (
   input  logic              clk,
   input  logic              rstn,
   input  logic              valid,
   input  sample_t           sample,
   input  logic              last,
   avg_result_if.lane        res
);

   lane_state_t state;
   lane_state_t state_next;
   sum_t        sum_q;
   sum_t        sum_next;
   count_t      cnt_q;
   count_t      cnt_next;
   logic        take;
   logic        new_burst;
   logic        start;
   logic        finish;
   sample_t     quotient;
   count_t      remainder;

   assign take      = valid && (state != DIVIDE);
   assign new_burst = (state == IDLE) || (state == DONE);
   assign start     = take && last;  // the divider loads the updated sum and count.

   // ------------------------------
   // accumulate
   // ------------------------------

   always_comb begin
      sum_next = sum_q;
      cnt_next = cnt_q;
      if (take) begin
         if (new_burst) begin
            sum_next = sum_t'(sample);
            cnt_next = count_t'(1);
         end else begin
            sum_next = sum_q + sum_t'(sample);
            cnt_next = cnt_q + count_t'(1);
         end
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         IDLE, DONE: if (take) state_next = last ? DIVIDE : ACCUM;
         ACCUM:      if (start) state_next = DIVIDE;
         DIVIDE:     if (finish) state_next = DONE;
         default:    state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state    <= IDLE;
         cnt_q    <= '0;
         res.done <= 1'b0;
      end else begin
         state    <= state_next;
         cnt_q    <= cnt_next;
         res.done <= finish;
      end
   end

   always_ff @(posedge clk) begin
      sum_q <= sum_next;
      // the result is held here until the next divide finishes.
      if (finish) begin
         res.mean  <= quotient;
         res.rem   <= remainder;
         res.count <= cnt_q;
      end
   end

   // ------------------------------
   // divider
   // ------------------------------

   serial_divider u_div (
      .clk       (clk),
      .rstn      (rstn),
      .start     (start),
      .dividend  (sum_next),
      .divisor   (cnt_next),
      .finish    (finish),
      .quotient  (quotient),
      .remainder (remainder)
   );

endmodule

//--- rtl/result_collector.sv
`timescale 1ns/10ps

module result_collector import avg_pkg::*; (
   input  logic             clk,
   input  logic             rstn,
   avg_result_if.collector  res [N_LANES],
   output logic             out_valid,
   output chan_t            out_chan,
   output sample_t          out_mean,
   output count_t           out_rem,
   output count_t           out_count
);

   logic [N_LANES-1:0] lane_done;
   sample_t            lane_mean  [N_LANES];
   count_t             lane_rem   [N_LANES];
   count_t             lane_count [N_LANES];

   logic [N_LANES-1:0] pend;
   sample_t            hold_mean  [N_LANES];
   count_t             hold_rem   [N_LANES];
   count_t             hold_count [N_LANES];

   chan_t              last_q;     // lane that was sent most recently.
   chan_t              pick;
   logic               pick_valid;

   // each lane's live result signals, one array entry per lane.
   for (genvar i = 0; i < N_LANES; i++) begin : g_tap
      assign lane_done[i]  = res[i].done;
      assign lane_mean[i]  = res[i].mean;
      assign lane_rem[i]   = res[i].rem;
      assign lane_count[i] = res[i].count;
   end

   // ------------------------------
   // round-robin pick
   // ------------------------------

   // the nearest pending lane after last_q is written last and wins.
   always_comb begin
      chan_t idx;
      pick_valid = 1'b0;
      pick       = last_q;
      for (int off = N_LANES; off >= 1; off--) begin
         idx = chan_t'(int'(last_q) + off);
         if (pend[idx]) begin
            pick_valid = 1'b1;
            pick       = idx;
         end
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         pend      <= '0;
         last_q    <= chan_t'(N_LANES - 1);  // lane 0 goes first.
         out_valid <= 1'b0;
      end else begin
         out_valid <= pick_valid;
         if (pick_valid) last_q <= pick;
         for (int i = 0; i < N_LANES; i++) begin
            if (lane_done[i]) begin
               pend[i] <= 1'b1;
            end else if (pick_valid && (pick == chan_t'(i))) begin
               pend[i] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < N_LANES; i++) begin
         if (lane_done[i]) begin
            hold_mean[i]  <= lane_mean[i];
            hold_rem[i]   <= lane_rem[i];
            hold_count[i] <= lane_count[i];
         end
      end
      if (pick_valid) begin
         out_chan  <= pick;
         out_mean  <= hold_mean[pick];
         out_rem   <= hold_rem[pick];
         out_count <= hold_count[pick];
      end
   end

endmodule

//--- rtl/avg_array.sv
`timescale 1ns/10ps

module avg_array import avg_pkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  logic    in_valid,
   input  chan_t   in_chan,
   input  sample_t in_sample,
   input  logic    in_last,
   output logic    out_valid,
   output chan_t   out_chan,
   output sample_t out_mean,
   output count_t  out_rem,
   output count_t  out_count
);

   logic [N_LANES-1:0] lane_valid;
   sample_t            lane_sample;
   logic               lane_last;

   avg_result_if res_if [N_LANES] ();

   sample_router u_router (
      .clk         (clk),
      .rstn        (rstn),
      .in_valid    (in_valid),
      .in_chan     (in_chan),
      .in_sample   (in_sample),
      .in_last     (in_last),
      .lane_valid  (lane_valid),
      .lane_sample (lane_sample),
      .lane_last   (lane_last)
   );

   // ------------------------------
   // lanes
   // ------------------------------

   for (genvar i = 0; i < N_LANES; i++) begin : g_lane
      burst_averager u_lane (
         .clk    (clk),
         .rstn   (rstn),
         .valid  (lane_valid[i]),
         .sample (lane_sample),
         .last   (lane_last),
         .res    (res_if[i])
      );
   end

   result_collector u_collector (
      .clk       (clk),
      .rstn      (rstn),
      .res       (res_if),
      .out_valid (out_valid),
      .out_chan  (out_chan),
      .out_mean  (out_mean),
      .out_rem   (out_rem),
      .out_count (out_count)
   );

endmodule

//--- tests/avg_array_sva.sv
`timescale 1ns/10ps

module avg_array_sva import avg_pkg::*; (
   input logic        clk,
   input logic        rstn,
   input logic        valid,
   input lane_state_t state,
   input count_t      cnt,
   input logic        done
);

   // a lane in DIVIDE drops samples, so none may reach it.
   no_sample_in_divide: assert property (
      @(posedge clk) disable iff (!rstn) (state == DIVIDE) |-> !valid
   ) else $error("sample reached a lane while it was dividing");

   no_count_wrap: assert property (
      @(posedge clk) disable iff (!rstn) (valid && state == ACCUM) |-> (cnt != count_t'(255))
   ) else $error("sample count of a burst wrapped past 255");

   // sixteen divide cycles plus the registered finish strobe.
   done_after_divide: assert property (
      @(posedge clk) disable iff (!rstn) $rose(state == DIVIDE) |-> ##17 done
   ) else $error("done did not follow 17 cycles after the start of the divide");

endmodule

bind burst_averager avg_array_sva u_sva (
   .clk   (clk),
   .rstn  (rstn),
   .valid (valid),
   .state (state),
   .cnt   (cnt_q),
   .done  (res.done)
);

//--- tests/tb_avg_array.sv
`timescale 1ns/10ps

module tb_avg_array import avg_pkg::*; ();

   typedef struct packed {
      sample_t mean;
      count_t  rem;
      count_t  count;
   } result_t;

   localparam int CLK_NS      = 40;
   localparam int GAP         = 20;  // quiet cycles on a channel after its last sample.
   localparam int MAX_LEN     = 40;
   localparam int N_SINGLE    = 8;
   localparam int N_INTER     = 6;
   localparam int N_BURSTS    = 2 * N_LANES + N_SINGLE + N_LANES * N_INTER + 1;
   localparam int MAX_SAMPLES = N_LANES + (N_BURSTS - N_LANES - 1) * MAX_LEN + 255;

   logic        clk;
   logic        rstn;
   logic        in_valid;
   chan_t       in_chan;
   sample_t     in_sample;
   logic        in_last;
   logic        out_valid;
   chan_t       out_chan;
   sample_t     out_mean;
   count_t      out_rem;
   count_t      out_count;

   logic [31:0] lfsr;
   int          cyc;
   int          acc_sum [N_LANES];
   int          acc_cnt [N_LANES];
   int          free_at [N_LANES];
   result_t     exp_q   [N_LANES][$];  // expected results per channel, oldest first.

   avg_array u_avg_array (
      .clk       (clk),
      .rstn      (rstn),
      .in_valid  (in_valid),
      .in_chan   (in_chan),
      .in_sample (in_sample),
      .in_last   (in_last),
      .out_valid (out_valid),
      .out_chan  (out_chan),
      .out_mean  (out_mean),
      .out_rem   (out_rem),
      .out_count (out_count)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // ------------------------------
   // reference and checks
   // ------------------------------

   // galois LFSR with taps x^32 + x^22 + x^2 + x + 1.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic int rand_len();
      return int'(rand_bits(6)) % MAX_LEN + 1;
   endfunction

   function automatic result_t avg_ref(input int sum, input int cnt);
      result_t r;
      r.mean  = sample_t'(sum / cnt);  // floor of the mean.
      r.rem   = count_t'(sum % cnt);
      r.count = count_t'(cnt);
      return r;
   endfunction

   function automatic int pending_total();
      int n;
      n = 0;
      for (int c = 0; c < N_LANES; c++) n += exp_q[c].size();
      return n;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      if (got !== exp)
         fail_run($sformatf("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
   endtask

   task automatic check_count(input string name, input count_t got, input count_t exp);
      if (got !== exp)
         fail_run($sformatf("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
   endtask

   task automatic check_chan(input chan_t got, input int waiting);
      if (waiting == 0)
         fail_run($sformatf("result on channel %0d at %0t, none was expected", got, $time));
   endtask

   // ------------------------------
   // stimulus
   // ------------------------------

   task automatic step();
      @(posedge clk);
      cyc++;
      in_valid <= 1'b0;
      in_last  <= 1'b0;
   endtask

   task automatic send(input chan_t ch, input sample_t s, input logic last);
      while (acc_cnt[ch] == 0 && cyc + 1 < free_at[ch]) step();  // lane may still divide.
      @(posedge clk);
      cyc++;
      in_valid  <= 1'b1;
      in_chan   <= ch;
      in_sample <= s;
      in_last   <= last;
      acc_sum[ch] += int'(s);
      acc_cnt[ch] += 1;
      if (last) begin
         exp_q[ch].push_back(avg_ref(acc_sum[ch], acc_cnt[ch]));
         acc_sum[ch] = 0;
         acc_cnt[ch] = 0;
         free_at[ch] = cyc + GAP;
      end
   endtask

   task automatic send_burst(input chan_t ch, input int len);
      for (int i = 0; i < len; i++) send(ch, sample_t'(rand_bits(SAMPLE_W)), i == len - 1);
   endtask

   task automatic send_interleaved();
      int    len  [N_LANES][N_INTER];
      int    bidx [N_LANES];
      int    pos  [N_LANES];
      int    left;
      chan_t ch;
      logic  found;
      left = N_LANES * N_INTER;
      for (int c = 0; c < N_LANES; c++) begin
         bidx[c] = 0;
         pos[c]  = 0;
         for (int b = 0; b < N_INTER; b++) len[c][b] = rand_len();
      end
      while (left > 0) begin
         ch    = chan_t'(rand_bits(CHAN_W));
         found = 1'b0;
         for (int k = 0; k < N_LANES; k++) begin
            if (!found && bidx[ch] < N_INTER && cyc + 1 >= free_at[ch]) begin
               found = 1'b1;
            end else if (!found) begin
               ch = ch + chan_t'(1);
            end
         end
         if (!found) begin
            step();  // every channel with work left is still dividing.
         end else if (pos[ch] == len[ch][bidx[ch]] - 1) begin
            send(ch, sample_t'(rand_bits(SAMPLE_W)), 1'b1);
            pos[ch] = 0;
            bidx[ch]++;
            left--;
         end else begin
            send(ch, sample_t'(rand_bits(SAMPLE_W)), 1'b0);
            pos[ch]++;
         end
      end
   endtask

   task automatic wait_free();
      for (int c = 0; c < N_LANES; c++) begin
         while (cyc + 1 < free_at[c]) step();
      end
   endtask

   // shorter bursts start later, so all last samples land in the final round.
   task automatic send_aligned();
      int len [N_LANES];
      int top;
      int i;
      top = 0;
      for (int c = 0; c < N_LANES; c++) begin
         len[c] = rand_len();
         if (len[c] > top) top = len[c];
      end
      wait_free();
      for (int r = 0; r < top; r++) begin
         for (int c = 0; c < N_LANES; c++) begin
            i = r - (top - len[c]);
            if (i >= 0) send(chan_t'(c), sample_t'(rand_bits(SAMPLE_W)), i == len[c] - 1);
         end
      end
   endtask

   initial begin
      int drain;
      lfsr      = 32'h52ed05d1;
      cyc       = 0;
      rstn      = 1'b0;
      in_valid  = 1'b0;
      in_chan   = '0;
      in_sample = '0;
      in_last   = 1'b0;
      for (int c = 0; c < N_LANES; c++) begin
         acc_sum[c] = 0;
         acc_cnt[c] = 0;
         free_at[c] = 0;
      end
      repeat (8) @(posedge clk);
      rstn <= 1'b1;
      repeat (10) begin
         step();
         @(negedge clk);
         if (out_valid !== 1'b0) fail_run("out_valid went high before any input");
      end
      for (int c = 0; c < N_LANES; c++) send(chan_t'(c), sample_t'(rand_bits(SAMPLE_W)), 1'b1);
      for (int b = 0; b < N_SINGLE; b++) send_burst(chan_t'(2), rand_len());
      send_interleaved();
      send_aligned();
      wait_free();
      for (int i = 0; i < 255; i++) send(chan_t'(3), '1, i == 254);  // full sum width.
      step();
      drain = 0;
      while (pending_total() != 0 && drain < 60) begin
         @(negedge clk);
         drain++;
      end
      repeat (10) @(negedge clk);
      if (pending_total() != 0) begin
         fail_run($sformatf("%0d expected results never appeared", pending_total()));
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

   // every out_valid takes the oldest expected result of its channel.
   initial begin
      result_t e;
      forever begin
         @(negedge clk);
         if (out_valid === 1'b1) begin
            check_chan(out_chan, exp_q[out_chan].size());
            e = exp_q[out_chan].pop_front();
            check_sample("out_mean", out_mean, e.mean);
            check_count("out_rem", out_rem, e.rem);
            check_count("out_count", out_count, e.count);
         end
      end
   end

   initial begin
      #((MAX_SAMPLES + 100 * N_BURSTS) * CLK_NS);
      fail_run("timeout, results are missing");
   end

endmodule

//--- sim.f
rtl/avg_pkg.sv
rtl/avg_result_if.sv
rtl/sample_router.sv
rtl/serial_divider.sv
rtl/burst_averager.sv
rtl/result_collector.sv
rtl/avg_array.sv
tests/avg_array_sva.sv
tests/tb_avg_array.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_avg_array \
   -f sim.f > sim.log 2>&1 \
   && ./obj_dir/Vtb_avg_array >> sim.log 2>&1 \
   || echo "Simulation failed" >> sim.log
cat sim.log
if grep -q "Simulation failed" sim.log; then
   exit 1
fi
grep -q "Simulation passed" sim.log || exit 1
exit 0
